// ==== Makefile ====
OBJ_DIR := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f filelist.f --top-module dispatch_top

sim:
	verilator --binary --timing -f filelist.f --top-module dispatch_tb \
		-Mdir $(OBJ_DIR) -o dispatch_sim
	./$(OBJ_DIR)/dispatch_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log

// ==== filelist.f ====
+incdir+sim
rtl/dispatch_pkg.sv
rtl/insn_intake.sv
rtl/insn_classify.sv
rtl/operand_extract.sv
rtl/dispatch_top.sv
sim/dispatch_tb.sv

// ==== rtl/dispatch_pkg.sv ====
package dispatch_pkg;

  // Decoded instruction classes, in encoding-table order
  typedef enum logic [4:0] {
    OP_LDUR, OP_STUR, OP_ADD, OP_SUB, OP_ADDS, OP_SUBS,
    OP_ORR, OP_EOR, OP_ANDS, OP_MOVK, OP_MOVZ, OP_ADRP,
    OP_CSEL, OP_CSINC, OP_B, OP_B_COND, OP_BL, OP_CBZ,
    OP_CBNZ, OP_RET, OP_NOP, OP_HLT, OP_ERR
  } opcode_t;

  typedef enum logic [1:0] {
    FU_ALU,
    FU_LS,
    FU_BR
  } fu_t;

  // PLUS is zero so an undecoded word leaves an all-zero ALU field
  typedef enum logic [2:0] {
    ALU_OP_PLUS, ALU_OP_MINUS, ALU_OP_OR, ALU_OP_EOR,
    ALU_OP_AND, ALU_OP_MOV, ALU_OP_CSEL, ALU_OP_CSINC
  } alu_op_t;

  typedef enum logic [3:0] {
    COND_EQ, COND_NE, COND_CS, COND_CC, COND_MI, COND_PL, COND_VS, COND_VC,
    COND_HI, COND_LS, COND_GE, COND_LT, COND_GT, COND_LE, COND_AL, COND_NV
  } cond_t;

  // Register form: Rm at 20:16, shift amount or cond/op bits at 15:10
  typedef struct packed {
    logic [10:0] top;
    logic [4:0]  rm;
    logic [5:0]  mid;
    logic [4:0]  rn;
    logic [4:0]  rd;
  } insn_reg_t;

  // Immediate form: imm12 at 21:10
  typedef struct packed {
    logic [9:0]  top;
    logic [11:0] imm12;
    logic [4:0]  rn;
    logic [4:0]  rd;
  } insn_imm_t;

  typedef union packed {
    insn_reg_t rform;
    insn_imm_t iform;
  } insn_u;

  typedef struct packed {
    insn_u   word;
    opcode_t op;
  } stage_t;

  typedef struct packed {
    opcode_t     op;
    fu_t         fu;
    alu_op_t     alu_op;
    logic [4:0]  src1;
    logic [4:0]  src2;
    logic [4:0]  dst;
    logic [63:0] imm;
    logic        use_imm;
    logic        set_nzcv;
    logic        writes_dst;
    cond_t       cond;
  } uop_t;

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  localparam int unsigned reg_insn  = 32'h0;
  localparam int unsigned reg_count = 32'h4;

endpackage

// ==== rtl/dispatch_top.sv ====
`timescale 1ns/1ps

module dispatch_top #(
  parameter int addr_w = 4
) (
  input  logic               in_clk,
  input  logic               rst_n,
  input  logic [addr_w-1:0]  awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  logic [31:0]        wdata,
  input  logic               wvalid,
  output logic               wready,
  output logic [1:0]         bresp,
  output logic               bvalid,
  input  logic               bready,
  input  logic [addr_w-1:0]  araddr,
  input  logic               arvalid,
  output logic               arready,
  output logic [31:0]        rdata,
  output logic [1:0]         rresp,
  output logic               rvalid,
  input  logic               rready,
  output dispatch_pkg::uop_t uop,
  output logic               uop_valid,
  input  logic               uop_ready
);

  dispatch_pkg::insn_u  s1_word;
  logic                 s1_valid;
  logic                 s1_ready;
  dispatch_pkg::stage_t s2;
  logic                 s2_valid;
  logic                 s2_ready;

  insn_intake #(.addr_w(addr_w)) i_intake (.*);

  insn_classify i_classify (.*);

  operand_extract i_extract (.*);

endmodule

// ==== rtl/insn_classify.sv ====
`timescale 1ns/1ps

module insn_classify (
  input  logic                 in_clk,
  input  logic                 rst_n,
  input  dispatch_pkg::insn_u  s1_word,
  input  logic                 s1_valid,
  output logic                 s1_ready,
  output dispatch_pkg::stage_t s2,
  output logic                 s2_valid,
  input  logic                 s2_ready
);

  dispatch_pkg::opcode_t op;

  // 64-bit encodings only, first match wins
  always_comb begin
    casez (s1_word)
      32'b1111_1000_010?_????_????_00??_????_????: op = dispatch_pkg::OP_LDUR;
      32'b1111_1000_000?_????_????_00??_????_????: op = dispatch_pkg::OP_STUR;
      // Shift bit 22 is not interpreted
      32'b1001_0001_0???_????_????_????_????_????: op = dispatch_pkg::OP_ADD;
      32'b1101_0001_0???_????_????_????_????_????: op = dispatch_pkg::OP_SUB;
      // Shifted register forms with LSL only
      32'b1010_1011_000?_????_????_????_????_????: op = dispatch_pkg::OP_ADDS;
      32'b1110_1011_000?_????_????_????_????_????: op = dispatch_pkg::OP_SUBS;
      32'b1010_1010_000?_????_????_????_????_????: op = dispatch_pkg::OP_ORR;
      32'b1100_1010_000?_????_????_????_????_????: op = dispatch_pkg::OP_EOR;
      32'b1110_1010_000?_????_????_????_????_????: op = dispatch_pkg::OP_ANDS;
      32'b1111_0010_1???_????_????_????_????_????: op = dispatch_pkg::OP_MOVK;
      32'b1101_0010_1???_????_????_????_????_????: op = dispatch_pkg::OP_MOVZ;
      32'b1??1_0000_????_????_????_????_????_????: op = dispatch_pkg::OP_ADRP;
      32'b1001_1010_100?_????_????_00??_????_????: op = dispatch_pkg::OP_CSEL;
      32'b1001_1010_100?_????_????_01??_????_????: op = dispatch_pkg::OP_CSINC;
      32'b0001_01??_????_????_????_????_????_????: op = dispatch_pkg::OP_B;
      32'b0101_0100_????_????_????_????_???0_????: op = dispatch_pkg::OP_B_COND;
      32'b1001_01??_????_????_????_????_????_????: op = dispatch_pkg::OP_BL;
      32'b1011_0100_????_????_????_????_????_????: op = dispatch_pkg::OP_CBZ;
      32'b1011_0101_????_????_????_????_????_????: op = dispatch_pkg::OP_CBNZ;
      32'b1101_0110_0101_1111_0000_00??_???0_0000: op = dispatch_pkg::OP_RET;
      32'b1101_0101_0000_0011_0010_0000_0001_1111: op = dispatch_pkg::OP_NOP;
      32'b1101_0100_010?_????_????_????_???0_0000: op = dispatch_pkg::OP_HLT;
      default: op = dispatch_pkg::OP_ERR;
    endcase
  end

  assign s1_ready = !s2_valid || s2_ready;

  // Stage 2 register
  always_ff @(posedge in_clk) begin
    if (!rst_n) begin
      s2_valid <= 1'b0;
    end else if (s1_valid && s1_ready) begin
      s2_valid <= 1'b1;
    end else if (s2_ready) begin
      s2_valid <= 1'b0;
    end
    if (s1_valid && s1_ready) begin
      s2.word <= s1_word;
      s2.op   <= op;
    end
  end

endmodule

// ==== rtl/insn_intake.sv ====
`timescale 1ns/1ps

module insn_intake #(
  parameter int addr_w = 4
) (
  input  logic                in_clk,
  input  logic                rst_n,
  input  logic [addr_w-1:0]   awaddr,
  input  logic                awvalid,
  output logic                awready,
  input  logic [31:0]         wdata,
  input  logic                wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  logic                bready,
  input  logic [addr_w-1:0]   araddr,
  input  logic                arvalid,
  output logic                arready,
  output logic [31:0]         rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  logic                rready,
  output dispatch_pkg::insn_u s1_word,
  output logic                s1_valid,
  input  logic                s1_ready
);

  logic        wr_is_insn;
  logic        s1_free;
  logic        wr_accept;
  logic        rd_accept;
  logic [31:0] insn_count;

  assign wr_is_insn = awaddr == addr_w'(dispatch_pkg::reg_insn);
  assign s1_free    = !s1_valid || s1_ready;

  // Address and data are taken in the same cycle, one response outstanding
  assign wr_accept = awvalid && wvalid && !bvalid && (!wr_is_insn || s1_free);
  assign awready   = wr_accept;
  assign wready    = wr_accept;
  assign rd_accept = arvalid && arready;

  // Stage 1 register
  always_ff @(posedge in_clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
    end else if (wr_accept && wr_is_insn) begin
      s1_valid <= 1'b1;
    end else if (s1_ready) begin
      s1_valid <= 1'b0;
    end
    if (wr_accept && wr_is_insn) begin
      s1_word <= wdata;
    end
  end

  always_ff @(posedge in_clk) begin
    if (!rst_n) begin
      bvalid     <= 1'b0;
      insn_count <= '0;
    end else if (wr_accept) begin
      bvalid <= 1'b1;
      bresp  <= wr_is_insn ? dispatch_pkg::resp_okay : dispatch_pkg::resp_slverr;
      if (wr_is_insn) begin
        insn_count <= insn_count + 32'd1;
      end
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // Read channel; arready comes up the cycle after reset and drops while rvalid is held
  always_ff @(posedge in_clk) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
    end else if (rd_accept) begin
      arready <= 1'b0;
      rvalid  <= 1'b1;
      if (araddr == addr_w'(dispatch_pkg::reg_count)) begin
        rdata <= insn_count;
        rresp <= dispatch_pkg::resp_okay;
      end else begin
        rdata <= '0;
        rresp <= dispatch_pkg::resp_slverr;
      end
    end else if (rvalid && rready) begin
      rvalid  <= 1'b0;
      arready <= 1'b1;
    end else if (!rvalid) begin
      arready <= 1'b1;
    end
  end

endmodule

// ==== rtl/operand_extract.sv ====
`timescale 1ns/1ps

module operand_extract (
  input  logic                 in_clk,
  input  logic                 rst_n,
  input  dispatch_pkg::stage_t s2,
  input  logic                 s2_valid,
  output logic                 s2_ready,
  output dispatch_pkg::uop_t   uop,
  output logic                 uop_valid,
  input  logic                 uop_ready
);

  dispatch_pkg::uop_t nxt;
  logic [31:0]        bits;
  logic [4:0]         rd;
  logic [4:0]         rn;
  logic [4:0]         rm;

  assign bits = s2.word;
  assign rd   = s2.word.iform.rd;
  assign rn   = s2.word.iform.rn;
  assign rm   = s2.word.rform.rm;

  always_comb begin
    nxt = '0;
    nxt.op = s2.op;
    case (s2.op)
      dispatch_pkg::OP_LDUR, dispatch_pkg::OP_STUR: begin
        nxt.fu      = dispatch_pkg::FU_LS;
        nxt.src1    = rn;
        // Signed imm9 offset sits across Rm and the top of the mid field
        nxt.imm     = {{55{bits[20]}}, s2.word.rform.rm, s2.word.rform.mid[5:2]};
        nxt.use_imm = 1'b1;
        if (s2.op == dispatch_pkg::OP_STUR) begin
          nxt.src2 = rd;
        end else begin
          nxt.dst        = rd;
          nxt.writes_dst = 1'b1;
        end
      end
      dispatch_pkg::OP_ADD, dispatch_pkg::OP_SUB: begin
        nxt.alu_op     = (s2.op == dispatch_pkg::OP_SUB) ? dispatch_pkg::ALU_OP_MINUS
                                                         : dispatch_pkg::ALU_OP_PLUS;
        nxt.src1       = rn;
        nxt.dst        = rd;
        nxt.writes_dst = 1'b1;
        nxt.imm        = {52'd0, s2.word.iform.imm12};
        nxt.use_imm    = 1'b1;
      end
      dispatch_pkg::OP_ADDS, dispatch_pkg::OP_SUBS, dispatch_pkg::OP_ORR,
      dispatch_pkg::OP_EOR, dispatch_pkg::OP_ANDS: begin
        case (s2.op)
          dispatch_pkg::OP_SUBS: nxt.alu_op = dispatch_pkg::ALU_OP_MINUS;
          dispatch_pkg::OP_ORR:  nxt.alu_op = dispatch_pkg::ALU_OP_OR;
          dispatch_pkg::OP_EOR:  nxt.alu_op = dispatch_pkg::ALU_OP_EOR;
          dispatch_pkg::OP_ANDS: nxt.alu_op = dispatch_pkg::ALU_OP_AND;
          default:               nxt.alu_op = dispatch_pkg::ALU_OP_PLUS;
        endcase
        nxt.set_nzcv   = s2.op inside {dispatch_pkg::OP_ADDS, dispatch_pkg::OP_SUBS,
                                       dispatch_pkg::OP_ANDS};
        nxt.src1       = rn;
        nxt.src2       = rm;
        nxt.dst        = rd;
        nxt.writes_dst = 1'b1;
      end
      dispatch_pkg::OP_MOVK, dispatch_pkg::OP_MOVZ: begin
        nxt.alu_op     = dispatch_pkg::ALU_OP_MOV;
        nxt.dst        = rd;
        nxt.writes_dst = 1'b1;
        nxt.imm        = {48'd0, bits[20:5]};
        nxt.use_imm    = 1'b1;
      end
      dispatch_pkg::OP_ADRP: begin
        nxt.dst        = rd;
        nxt.writes_dst = 1'b1;
        // immhi:immlo is a signed page count
        nxt.imm        = {{31{bits[23]}}, bits[23:5], bits[30:29], 12'h000};
        nxt.use_imm    = 1'b1;
      end
      dispatch_pkg::OP_CSEL, dispatch_pkg::OP_CSINC: begin
        nxt.alu_op     = (s2.op == dispatch_pkg::OP_CSINC) ? dispatch_pkg::ALU_OP_CSINC
                                                           : dispatch_pkg::ALU_OP_CSEL;
        nxt.src1       = rn;
        nxt.src2       = rm;
        nxt.dst        = rd;
        nxt.writes_dst = 1'b1;
        nxt.cond       = dispatch_pkg::cond_t'(bits[15:12]);
      end
      dispatch_pkg::OP_B: nxt.fu = dispatch_pkg::FU_BR;
      dispatch_pkg::OP_B_COND: begin
        nxt.fu   = dispatch_pkg::FU_BR;
        nxt.cond = dispatch_pkg::cond_t'(bits[3:0]);
      end
      dispatch_pkg::OP_BL: begin
        // Link register
        nxt.fu         = dispatch_pkg::FU_BR;
        nxt.dst        = 5'd30;
        nxt.writes_dst = 1'b1;
      end
      dispatch_pkg::OP_CBZ, dispatch_pkg::OP_CBNZ: begin
        nxt.fu   = dispatch_pkg::FU_BR;
        nxt.src1 = rd;
      end
      dispatch_pkg::OP_RET: begin
        nxt.fu   = dispatch_pkg::FU_BR;
        nxt.src1 = rn;
      end
      default: ;
    endcase
  end

  assign s2_ready = !uop_valid || uop_ready;

  // Stage 3 register, held while the consumer stalls
  always_ff @(posedge in_clk) begin
    if (!rst_n) begin
      uop_valid <= 1'b0;
    end else if (s2_valid && s2_ready) begin
      uop_valid <= 1'b1;
    end else if (uop_ready) begin
      uop_valid <= 1'b0;
    end
    if (s2_valid && s2_ready) begin
      uop <= nxt;
    end
  end

endmodule

// ==== sim/ref_decode.svh ====
// Encoding table in opcode order, as {mask, match value}
function automatic logic [63:0] enc_pattern(input int idx);
  case (idx)
    0:  return {32'hFFE0_0C00, 32'hF840_0000};  // LDUR
    1:  return {32'hFFE0_0C00, 32'hF800_0000};  // STUR
    2:  return {32'hFF80_0000, 32'h9100_0000};  // ADD imm
    3:  return {32'hFF80_0000, 32'hD100_0000};  // SUB imm
    4:  return {32'hFFE0_0000, 32'hAB00_0000};  // ADDS
    5:  return {32'hFFE0_0000, 32'hEB00_0000};  // SUBS
    6:  return {32'hFFE0_0000, 32'hAA00_0000};  // ORR
    7:  return {32'hFFE0_0000, 32'hCA00_0000};  // EOR
    8:  return {32'hFFE0_0000, 32'hEA00_0000};  // ANDS
    9:  return {32'hFF80_0000, 32'hF280_0000};  // MOVK
    10: return {32'hFF80_0000, 32'hD280_0000};  // MOVZ
    11: return {32'h9F00_0000, 32'h9000_0000};  // ADRP
    12: return {32'hFFE0_0C00, 32'h9A80_0000};  // CSEL
    13: return {32'hFFE0_0C00, 32'h9A80_0400};  // CSINC
    14: return {32'hFC00_0000, 32'h1400_0000};  // B
    15: return {32'hFF00_0010, 32'h5400_0000};  // B.cond
    16: return {32'hFC00_0000, 32'h9400_0000};  // BL
    17: return {32'hFF00_0000, 32'hB400_0000};  // CBZ
    18: return {32'hFF00_0000, 32'hB500_0000};  // CBNZ
    19: return {32'hFFFF_FC1F, 32'hD65F_0000};  // RET
    20: return {32'hFFFF_FFFF, 32'hD503_201F};  // NOP
    21: return {32'hFFE0_001F, 32'hD440_0000};  // HLT
    default: return {32'h0, 32'hFFFF_FFFF};
  endcase
endfunction

// First matching table entry, error class when none
function automatic dispatch_pkg::opcode_t ref_class(input logic [31:0] w);
  logic [63:0] p;
  for (int i = 0; i < 22; i++) begin
    p = enc_pattern(i);
    if ((w & p[63:32]) == p[31:0]) begin
      return dispatch_pkg::opcode_t'(i);
    end
  end
  return dispatch_pkg::OP_ERR;
endfunction

// Expected micro-op, built one field at a time from the dispatch rules
function automatic dispatch_pkg::uop_t ref_uop(input logic [31:0] w);
  dispatch_pkg::uop_t    u;
  dispatch_pkg::opcode_t op;
  logic                  alu_class;
  op        = ref_class(w);
  alu_class = op >= dispatch_pkg::OP_ADD && op <= dispatch_pkg::OP_CSINC;
  u         = '0;
  u.op      = op;
  if (op <= dispatch_pkg::OP_STUR) begin
    u.fu = dispatch_pkg::FU_LS;
  end else if (op >= dispatch_pkg::OP_B && op <= dispatch_pkg::OP_RET) begin
    u.fu = dispatch_pkg::FU_BR;
  end
  u.writes_dst = alu_class || op == dispatch_pkg::OP_LDUR || op == dispatch_pkg::OP_BL;
  if (op == dispatch_pkg::OP_BL) begin
    u.dst = 5'd30;
  end else if (u.writes_dst) begin
    u.dst = w[4:0];
  end
  if (op == dispatch_pkg::OP_CBZ || op == dispatch_pkg::OP_CBNZ) begin
    u.src1 = w[4:0];
  end else if (op <= dispatch_pkg::OP_ANDS || op == dispatch_pkg::OP_CSEL ||
               op == dispatch_pkg::OP_CSINC || op == dispatch_pkg::OP_RET) begin
    u.src1 = w[9:5];
  end
  if ((op >= dispatch_pkg::OP_ADDS && op <= dispatch_pkg::OP_ANDS) ||
      op == dispatch_pkg::OP_CSEL || op == dispatch_pkg::OP_CSINC) begin
    u.src2 = w[20:16];
  end else if (op == dispatch_pkg::OP_STUR) begin
    u.src2 = w[4:0];
  end
  case (op)
    dispatch_pkg::OP_LDUR, dispatch_pkg::OP_STUR: u.imm = {{55{w[20]}}, w[20:12]};
    dispatch_pkg::OP_ADD, dispatch_pkg::OP_SUB:   u.imm = {52'd0, w[21:10]};
    dispatch_pkg::OP_MOVK, dispatch_pkg::OP_MOVZ: u.imm = {48'd0, w[20:5]};
    // Signed page count from immhi:immlo, scaled to a 4 KiB page
    dispatch_pkg::OP_ADRP: u.imm = 64'($signed({w[23:5], w[30:29]})) << 12;
    default: u.imm = '0;
  endcase
  u.use_imm = op <= dispatch_pkg::OP_SUB || op == dispatch_pkg::OP_MOVK ||
              op == dispatch_pkg::OP_MOVZ || op == dispatch_pkg::OP_ADRP;
  case (op)
    dispatch_pkg::OP_SUB, dispatch_pkg::OP_SUBS:  u.alu_op = dispatch_pkg::ALU_OP_MINUS;
    dispatch_pkg::OP_ORR:                         u.alu_op = dispatch_pkg::ALU_OP_OR;
    dispatch_pkg::OP_EOR:                         u.alu_op = dispatch_pkg::ALU_OP_EOR;
    dispatch_pkg::OP_ANDS:                        u.alu_op = dispatch_pkg::ALU_OP_AND;
    dispatch_pkg::OP_MOVK, dispatch_pkg::OP_MOVZ: u.alu_op = dispatch_pkg::ALU_OP_MOV;
    dispatch_pkg::OP_CSEL:                        u.alu_op = dispatch_pkg::ALU_OP_CSEL;
    dispatch_pkg::OP_CSINC:                       u.alu_op = dispatch_pkg::ALU_OP_CSINC;
    default:                                      u.alu_op = dispatch_pkg::ALU_OP_PLUS;
  endcase
  u.set_nzcv = op == dispatch_pkg::OP_ADDS || op == dispatch_pkg::OP_SUBS ||
               op == dispatch_pkg::OP_ANDS;
  if (op == dispatch_pkg::OP_B_COND) begin
    u.cond = dispatch_pkg::cond_t'(w[3:0]);
  end else if (op == dispatch_pkg::OP_CSEL || op == dispatch_pkg::OP_CSINC) begin
    u.cond = dispatch_pkg::cond_t'(w[15:12]);
  end
  return u;
endfunction

// ==== sim/dispatch_tb.sv ====
`timescale 1ns/1ps

module dispatch_tb;

  localparam int addr_w     = 4;
  localparam int n_template = 400;
  localparam int n_random   = 100;
  // One instruction write and at most one extra access per step, plus the closing reads
  localparam int max_txn     = 2 * (n_template + n_random) + 4;
  localparam int cycle_limit = 40 * max_txn + 200;

  logic               in_clk;
  logic               rst_n;
  logic [addr_w-1:0]  awaddr;
  logic               awvalid;
  logic               awready;
  logic [31:0]        wdata;
  logic               wvalid;
  logic               wready;
  logic [1:0]         bresp;
  logic               bvalid;
  logic               bready;
  logic [addr_w-1:0]  araddr;
  logic               arvalid;
  logic               arready;
  logic [31:0]        rdata;
  logic [1:0]         rresp;
  logic               rvalid;
  logic               rready;
  dispatch_pkg::uop_t uop;
  logic               uop_valid;
  logic               uop_ready;

  logic [31:0]        lfsr_state;
  logic [31:0]        ready_lfsr;
  int                 insn_count;
  int                 cycles;
  dispatch_pkg::uop_t exp_q[$];
  dispatch_pkg::uop_t held;
  logic               stalled;

  dispatch_top #(.addr_w(addr_w)) i_dut (.*);

  `include "ref_decode.svh"

  initial begin
    in_clk = 1'b0;
    forever #20 in_clk = ~in_clk;
  end

  // Galois LFSR, one step for every bit drawn
  function automatic logic [31:0] rand_bits(inout logic [31:0] state, input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], state[0]};
      state = state[0] ? (state >> 1) ^ 32'hA300_0000 : state >> 1;
    end
    return v;
  endfunction

  function automatic logic [addr_w-1:0] addr_other_than(input logic [addr_w-1:0] taken);
    logic [addr_w-1:0] a;
    a = addr_w'(rand_bits(lfsr_state, addr_w));
    return (a == taken) ? a ^ {1'b1, {(addr_w - 1){1'b0}}} : a;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic compare_uop(input string name, input dispatch_pkg::uop_t exp,
                             input dispatch_pkg::uop_t got);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
    end
  endtask

  task automatic compare_resp(input string name, input logic [1:0] exp, input logic [1:0] got);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
    end
  endtask

  task automatic compare_data(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s exp=%h got=%h", name, exp, got));
    end
  endtask

  // AXI write with a random bready delay; instruction words are queued at acceptance
  task automatic write_reg(input logic [addr_w-1:0] addr, input logic [31:0] data,
                           input logic [1:0] exp_resp);
    int delay;
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    @(posedge in_clk);
    while (!(awready && wready)) begin
      @(posedge in_clk);
    end
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    if (addr == addr_w'(dispatch_pkg::reg_insn)) begin
      exp_q.push_back(ref_uop(data));
      insn_count++;
    end
    delay = rand_bits(lfsr_state, 2);
    bready <= (delay == 0);
    @(posedge in_clk);
    while (!(bvalid && bready)) begin
      delay--;
      bready <= (delay <= 0);
      @(posedge in_clk);
    end
    bready <= 1'b0;
    compare_resp("bresp", exp_resp, bresp);
  endtask

  task automatic read_reg(input logic [addr_w-1:0] addr, input logic [31:0] exp_data,
                          input logic [1:0] exp_resp);
    int delay;
    araddr  <= addr;
    arvalid <= 1'b1;
    @(posedge in_clk);
    while (!arready) begin
      @(posedge in_clk);
    end
    arvalid <= 1'b0;
    delay = rand_bits(lfsr_state, 2);
    rready <= (delay == 0);
    @(posedge in_clk);
    while (!(rvalid && rready)) begin
      delay--;
      rready <= (delay <= 0);
      @(posedge in_clk);
    end
    rready <= 1'b0;
    compare_data("rdata", exp_data, rdata);
    compare_resp("rresp", exp_resp, rresp);
  endtask

  // Micro-op consumer with random stalls, drawing from its own LFSR stream
  initial begin
    uop_ready = 1'b0;
    stalled   = 1'b0;
    forever begin
      @(posedge in_clk);
      if (rst_n) begin
        if (stalled) begin
          compare_flag("uop_valid", 1'b1, uop_valid);
          compare_uop("uop_held", held, uop);
        end
        if (uop_valid && uop_ready) begin
          if (exp_q.size() == 0) begin
            report_failure("a micro-op came out with no instruction left to match it");
          end
          compare_uop("uop", exp_q.pop_front(), uop);
          stalled = 1'b0;
        end else begin
          held    = uop;
          stalled = uop_valid;
        end
        uop_ready <= (rand_bits(ready_lfsr, 2) != 32'd0);
      end
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge in_clk);
      cycles++;
      if (cycles >= cycle_limit) begin
        report_failure($sformatf("run exceeded the cycle limit of %0d", cycle_limit));
      end
    end
  end

  initial begin
    logic [31:0] word;
    logic [63:0] pat;
    logic [31:0] pick;
    lfsr_state = 32'hc37b_0d48;
    ready_lfsr = rand_bits(lfsr_state, 32) | 32'd1;
    insn_count = 0;
    rst_n      = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    repeat (3) @(posedge in_clk);
    rst_n <= 1'b1;
    @(posedge in_clk);
    compare_flag("awready", 1'b0, awready);
    compare_flag("wready", 1'b0, wready);
    compare_flag("arready", 1'b0, arready);
    compare_flag("bvalid", 1'b0, bvalid);
    compare_flag("rvalid", 1'b0, rvalid);
    compare_flag("uop_valid", 1'b0, uop_valid);

    // Template words first, then fully random words
    for (int i = 0; i < n_template + n_random; i++) begin
      word = rand_bits(lfsr_state, 32);
      if (i < n_template) begin
        pat  = enc_pattern(int'(rand_bits(lfsr_state, 5) % 32'd22));
        word = (word & ~pat[63:32]) | pat[31:0];
      end
      write_reg(addr_w'(dispatch_pkg::reg_insn), word, dispatch_pkg::resp_okay);
      pick = rand_bits(lfsr_state, 3);
      case (pick)
        32'd0: write_reg(addr_other_than(addr_w'(dispatch_pkg::reg_insn)),
                         rand_bits(lfsr_state, 32), dispatch_pkg::resp_slverr);
        32'd1: read_reg(addr_w'(dispatch_pkg::reg_count), insn_count, dispatch_pkg::resp_okay);
        32'd2: read_reg(addr_other_than(addr_w'(dispatch_pkg::reg_count)), 32'd0,
                        dispatch_pkg::resp_slverr);
        default: ;
      endcase
    end
    read_reg(addr_w'(dispatch_pkg::reg_count), insn_count, dispatch_pkg::resp_okay);
    read_reg(addr_other_than(addr_w'(dispatch_pkg::reg_count)), 32'd0, dispatch_pkg::resp_slverr);

    while (exp_q.size() != 0) begin
      @(posedge in_clk);
    end
    // Pipeline depth is three, so any extra micro-op shows within four cycles
    repeat (4) @(posedge in_clk);
    compare_flag("uop_valid", 1'b0, uop_valid);
    $display("All tests passed");
    $finish;
  end

endmodule
